// ==== common/snake_pkg.sv ====
package snake_pkg;

    // Segment index, A through G
    typedef logic [2:0] seg_idx_t;

    // One bit per segment, bit i is segment i
    typedef logic [6:0] seg_mask_t;

    localparam int NUM_SEGS = 7;

    localparam seg_idx_t SEG_A = 3'd0;
    localparam seg_idx_t SEG_B = 3'd1;
    localparam seg_idx_t SEG_C = 3'd2;
    localparam seg_idx_t SEG_D = 3'd3;
    localparam seg_idx_t SEG_E = 3'd4;
    localparam seg_idx_t SEG_F = 3'd5;
    localparam seg_idx_t SEG_G = 3'd6;

    // Consecutive high samples before a button counts as pressed
    localparam int DEBOUNCE_LEN = 4;

    // About half a second at 100 MHz
    localparam int HALF_TICK_CYCLES_DEFAULT = 50_000_000;

    localparam int INIT_SECONDS = 3;
    localparam int FALL_HALF_TICKS = 1;

    // Shared phase tick counter must hold the larger of the two limits
    localparam int TICK_CNT_MAX = (INIT_SECONDS > FALL_HALF_TICKS) ?
                                  INIT_SECONDS : FALL_HALF_TICKS;
    localparam int TICK_CNT_W = $clog2(TICK_CNT_MAX + 1);

    typedef logic [TICK_CNT_W-1:0] tick_cnt_t;

    typedef enum logic [1:0] {
        RIGHT,
        LEFT,
        UP,
        DOWN
    } heading_e;

    typedef enum logic [1:0] {
        PH_INIT,
        PH_MOVE,
        PH_FALL
    } phase_e;

    // One-cycle press strobes
    typedef struct packed {
        logic right;
        logic left;
        logic up;
        logic down;
    } btn_evt_t;

    typedef struct packed {
        seg_idx_t seg;
        heading_e head;
    } walk_t;

endpackage

// ==== compile.f ====
common/snake_pkg.sv
hw/button_conditioner.sv
hw/tick_gen.sv
snake/snake_phase_ctrl.sv
snake/segment_walker.sv
snake/segment_display.sv
hw/snake_top.sv
verif/tb_clock.sv
verif/snake_tb.sv

// ==== hw/button_conditioner.sv ====
`timescale 1ns/1ps

module button_conditioner (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 right,
    input  logic                 left,
    input  logic                 up,
    input  logic                 down,
    output snake_pkg::btn_evt_t  evt
);

    localparam int NUM_BTNS = $bits(snake_pkg::btn_evt_t);
    localparam int LEN = snake_pkg::DEBOUNCE_LEN;

    logic [NUM_BTNS-1:0] btn_raw;
    logic [NUM_BTNS-1:0] press;

    // Same order as the fields of btn_evt_t
    assign btn_raw = {right, left, up, down};

    for (genvar i = 0; i < NUM_BTNS; i++) begin : g_lane
        logic [LEN-1:0] samples;
        logic           level;
        logic           level_q;

        // Debounced level is high once the whole window is high
        assign level = &samples;

        always_ff @(posedge clk or posedge rst) begin
            if (rst) begin
                samples <= '0;
                level_q <= 1'b0;
            end else begin
                samples <= {samples[LEN-2:0], btn_raw[i]};
                level_q <= level;
            end
        end

        assign press[i] = level & ~level_q;
    end

    assign evt = snake_pkg::btn_evt_t'(press);

endmodule

// ==== hw/snake_top.sv ====
`timescale 1ns/1ps

module snake_top #(
    parameter int CYCLES_PER_HALF = snake_pkg::HALF_TICK_CYCLES_DEFAULT
) (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 right,
    input  logic                 left,
    input  logic                 up,
    input  logic                 down,
    output snake_pkg::seg_mask_t seg,
    output logic                 init,
    output logic                 move,
    output logic                 fall,
    output snake_pkg::heading_e  pos
);

    snake_pkg::btn_evt_t  evt;
    snake_pkg::phase_e    phase;
    snake_pkg::walk_t     walk;
    snake_pkg::seg_mask_t visited;
    logic                 all_visited;
    logic                 half_tick;
    logic                 sec_tick;

    button_conditioner button_conditioner_i (
        .clk   (clk),
        .rst   (rst),
        .right (right),
        .left  (left),
        .up    (up),
        .down  (down),
        .evt   (evt)
    );

    tick_gen #(
        .CYCLES_PER_HALF (CYCLES_PER_HALF)
    ) tick_gen_i (
        .clk       (clk),
        .rst       (rst),
        .half_tick (half_tick),
        .sec_tick  (sec_tick)
    );

    snake_phase_ctrl snake_phase_ctrl_i (
        .clk         (clk),
        .rst         (rst),
        .evt         (evt),
        .half_tick   (half_tick),
        .sec_tick    (sec_tick),
        .all_visited (all_visited),
        .phase       (phase)
    );

    segment_walker segment_walker_i (
        .clk         (clk),
        .rst         (rst),
        .evt         (evt),
        .phase       (phase),
        .walk        (walk),
        .visited     (visited),
        .all_visited (all_visited)
    );

    segment_display segment_display_i (
        .clk       (clk),
        .rst       (rst),
        .phase     (phase),
        .walk      (walk),
        .visited   (visited),
        .half_tick (half_tick),
        .seg       (seg)
    );

    assign init = (phase == snake_pkg::PH_INIT);
    assign move = (phase == snake_pkg::PH_MOVE);
    assign fall = (phase == snake_pkg::PH_FALL);
    assign pos  = walk.head;

endmodule

// ==== hw/tick_gen.sv ====
`timescale 1ns/1ps

module tick_gen #(
    parameter int CYCLES_PER_HALF = snake_pkg::HALF_TICK_CYCLES_DEFAULT
) (
    input  logic clk,
    input  logic rst,
    output logic half_tick,
    output logic sec_tick
);

    localparam int CNT_W = (CYCLES_PER_HALF > 1) ? $clog2(CYCLES_PER_HALF) : 1;
    localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(CYCLES_PER_HALF - 1);

    logic [CNT_W-1:0] cnt;
    logic             odd_half;

    assign half_tick = (cnt == CNT_LAST);

    // Every second half-tick is also a second tick
    assign sec_tick = half_tick & odd_half;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt      <= '0;
            odd_half <= 1'b0;
        end else begin
            if (half_tick) begin
                cnt      <= '0;
                odd_half <= ~odd_half;
            end else begin
                cnt <= cnt + CNT_W'(1);
            end
        end
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the snake testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module snake_tb -f compile.f -o snake_sim > build.log 2>&1 \
    && ./obj_dir/snake_sim > sim.log 2>&1 \
    || { cat build.log; echo "Build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Checks failed" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

// ==== snake/segment_display.sv ====
`timescale 1ns/1ps

module segment_display (
    input  logic                 clk,
    input  logic                 rst,
    input  snake_pkg::phase_e    phase,
    input  snake_pkg::walk_t     walk,
    input  snake_pkg::seg_mask_t visited,
    input  logic                 half_tick,
    output snake_pkg::seg_mask_t seg
);

    logic                 blink;
    snake_pkg::seg_mask_t cur_bit;
    snake_pkg::seg_mask_t lit;

    assign cur_bit = snake_pkg::seg_mask_t'(1) << walk.seg;

    // Blink phase only runs during fall
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            blink <= 1'b0;
        end else if (phase != snake_pkg::PH_FALL) begin
            blink <= 1'b0;
        end else if (half_tick) begin
            blink <= ~blink;
        end
    end

    always_comb begin
        if (phase == snake_pkg::PH_FALL) begin
            lit = visited ^ (blink ? cur_bit : '0);
        end else begin
            // Walk sits on G throughout init
            lit = cur_bit;
        end
    end

    // Segments are active low
    assign seg = ~lit;

endmodule

// ==== snake/segment_walker.sv ====
`timescale 1ns/1ps

module segment_walker (
    input  logic                 clk,
    input  logic                 rst,
    input  snake_pkg::btn_evt_t  evt,
    input  snake_pkg::phase_e    phase,
    output snake_pkg::walk_t     walk,
    output snake_pkg::seg_mask_t visited,
    output logic                 all_visited
);

    localparam snake_pkg::walk_t WALK_START = '{seg: snake_pkg::SEG_G, head: snake_pkg::LEFT};

    snake_pkg::walk_t     next_walk;
    snake_pkg::seg_mask_t cur_bit;

    assign cur_bit = snake_pkg::seg_mask_t'(1) << walk.seg;
    assign all_visited = &visited;

    // Walk table, each chain ordered right, left, up for priority
    always_comb begin
        next_walk = walk;
        case (walk.seg)
            snake_pkg::SEG_A: begin
                if (walk.head == snake_pkg::RIGHT && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_B, head: snake_pkg::DOWN};
                end else if (walk.head == snake_pkg::LEFT && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_F, head: snake_pkg::DOWN};
                end
            end
            snake_pkg::SEG_B: begin
                if (walk.head == snake_pkg::DOWN && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_G, head: snake_pkg::LEFT};
                end else if (walk.head == snake_pkg::UP && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_A, head: snake_pkg::LEFT};
                end else if (walk.head == snake_pkg::DOWN && evt.up) begin
                    next_walk = '{seg: snake_pkg::SEG_C, head: snake_pkg::DOWN};
                end
            end
            snake_pkg::SEG_C: begin
                if (walk.head == snake_pkg::DOWN && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_D, head: snake_pkg::DOWN};
                end else if (walk.head == snake_pkg::UP && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_G, head: snake_pkg::LEFT};
                end else if (walk.head == snake_pkg::UP && evt.up) begin
                    next_walk = '{seg: snake_pkg::SEG_B, head: snake_pkg::UP};
                end
            end
            snake_pkg::SEG_D: begin
                if (walk.head == snake_pkg::LEFT && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_E, head: snake_pkg::UP};
                end else if (walk.head == snake_pkg::RIGHT && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_C, head: snake_pkg::UP};
                end
            end
            snake_pkg::SEG_E: begin
                if (walk.head == snake_pkg::UP && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_G, head: snake_pkg::RIGHT};
                end else if (walk.head == snake_pkg::DOWN && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_D, head: snake_pkg::RIGHT};
                end else if (walk.head == snake_pkg::UP && evt.up) begin
                    next_walk = '{seg: snake_pkg::SEG_F, head: snake_pkg::UP};
                end
            end
            snake_pkg::SEG_F: begin
                if (walk.head == snake_pkg::UP && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_A, head: snake_pkg::RIGHT};
                end else if (walk.head == snake_pkg::DOWN && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_G, head: snake_pkg::RIGHT};
                end
            end
            snake_pkg::SEG_G: begin
                if (walk.head == snake_pkg::RIGHT && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_C, head: snake_pkg::DOWN};
                end else if (walk.head == snake_pkg::LEFT && evt.right) begin
                    next_walk = '{seg: snake_pkg::SEG_F, head: snake_pkg::UP};
                end else if (walk.head == snake_pkg::RIGHT && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_B, head: snake_pkg::UP};
                end else if (walk.head == snake_pkg::LEFT && evt.left) begin
                    next_walk = '{seg: snake_pkg::SEG_E, head: snake_pkg::DOWN};
                end
            end
            default: begin
                next_walk = WALK_START;
            end
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            walk    <= WALK_START;
            visited <= '0;
        end else begin
            case (phase)
                snake_pkg::PH_MOVE: begin
                    walk    <= next_walk;
                    visited <= '0;
                end
                // Mark where the walk stands, the new segment lands next cycle
                snake_pkg::PH_FALL: begin
                    walk    <= next_walk;
                    visited <= visited | cur_bit;
                end
                default: begin
                    walk    <= WALK_START;
                    visited <= '0;
                end
            endcase
        end
    end

endmodule

// ==== snake/snake_phase_ctrl.sv ====
`timescale 1ns/1ps

module snake_phase_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  snake_pkg::btn_evt_t evt,
    input  logic                half_tick,
    input  logic                sec_tick,
    input  logic                all_visited,
    output snake_pkg::phase_e   phase
);

    localparam snake_pkg::tick_cnt_t INIT_LAST =
        snake_pkg::tick_cnt_t'(snake_pkg::INIT_SECONDS - 1);
    localparam snake_pkg::tick_cnt_t FALL_LAST =
        snake_pkg::tick_cnt_t'(snake_pkg::FALL_HALF_TICKS - 1);

    snake_pkg::tick_cnt_t tick_cnt;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            phase    <= snake_pkg::PH_INIT;
            tick_cnt <= '0;
        end else begin
            case (phase)
                snake_pkg::PH_INIT: begin
                    // Count second ticks until init is over
                    if (sec_tick) begin
                        if (tick_cnt == INIT_LAST) begin
                            phase    <= snake_pkg::PH_MOVE;
                            tick_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + snake_pkg::tick_cnt_t'(1);
                        end
                    end
                end

                snake_pkg::PH_MOVE: begin
                    if (evt.down) begin
                        phase    <= snake_pkg::PH_FALL;
                        tick_cnt <= '0;
                    end
                end

                snake_pkg::PH_FALL: begin
                    // Only half ticks with a full mask count
                    if (half_tick && all_visited) begin
                        if (tick_cnt == FALL_LAST) begin
                            phase    <= snake_pkg::PH_INIT;
                            tick_cnt <= '0;
                        end else begin
                            tick_cnt <= tick_cnt + snake_pkg::tick_cnt_t'(1);
                        end
                    end
                end

                default: begin
                    phase    <= snake_pkg::PH_INIT;
                    tick_cnt <= '0;
                end
            endcase
        end
    end

endmodule

// ==== verif/snake_tb.sv ====
`timescale 1ns/1ps

module snake_tb;

    localparam int CYCLES_PER_HALF = 8;
    localparam int PRESS_CYCLES = snake_pkg::DEBOUNCE_LEN + 3;
    localparam int RELEASE_CYCLES = 3;
    localparam int MAX_CYCLES = 3000;
    localparam int NUM_RANDOM = 20;

    // Button lanes of the reference table
    localparam int BTN_RIGHT = 0;
    localparam int BTN_LEFT = 1;
    localparam int BTN_UP = 2;
    localparam int BTN_DOWN = 3;

    localparam int H_RIGHT = 0;
    localparam int H_LEFT = 1;
    localparam int H_UP = 2;
    localparam int H_DOWN = 3;

    localparam int S_A = 0;
    localparam int S_B = 1;
    localparam int S_C = 2;
    localparam int S_D = 3;
    localparam int S_E = 4;
    localparam int S_F = 5;
    localparam int S_G = 6;

    logic                 clk;
    logic                 rst;
    logic                 right;
    logic                 left;
    logic                 up;
    logic                 down;
    snake_pkg::seg_mask_t seg;
    logic                 init;
    logic                 move;
    logic                 fall;
    snake_pkg::heading_e  pos;

    int err_count;
    int check_count;
    int test_count;
    int cycle_count;
    int order_fails;
    int phase_fails;
    int onehot_fails;
    int seed;

    // Reference model of the walk
    int                   m_seg;
    int                   m_head;
    snake_pkg::seg_mask_t m_visited;
    int                   next_seg [7][4][4];
    int                   next_head [7][4][4];

    // Fall route from G/LEFT that visits every segment
    int r_seq [7] = '{BTN_LEFT, BTN_LEFT, BTN_LEFT, BTN_UP, BTN_LEFT, BTN_LEFT, BTN_LEFT};

    tb_clock tb_clock_i (
        .clk (clk)
    );

    snake_top #(
        .CYCLES_PER_HALF (CYCLES_PER_HALF)
    ) snake_top_i (
        .clk   (clk),
        .rst   (rst),
        .right (right),
        .left  (left),
        .up    (up),
        .down  (down),
        .seg   (seg),
        .init  (init),
        .move  (move),
        .fall  (fall),
        .pos   (pos)
    );

    // Phases only advance init, move, fall, init
    a_phase_order: assert property (@(posedge clk) disable iff (rst)
        !$stable({init, move, fall}) |->
            (move && $past(init)) || (fall && $past(move)) || (init && $past(fall)))
    else begin
        $display("[ERROR] %0t: phase changed out of order", $time);
        order_fails++;
    end

    a_phase_onehot: assert property (@(posedge clk) disable iff (rst)
        $onehot({init, move, fall}))
    else begin
        $display("[ERROR] %0t: phase outputs not one-hot", $time);
        phase_fails++;
    end

    a_move_onehot: assert property (@(posedge clk) disable iff (rst)
        move |-> $onehot(~seg))
    else begin
        $display("[ERROR] %0t: more than one segment lit in move", $time);
        onehot_fails++;
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
            $display("Checks failed");
            $finish;
        end
    end

    function automatic int total_errors();
        return err_count + order_fails + phase_fails + onehot_fails;
    endfunction

    task automatic add_move(input int s, input int h, input int b, input int ns,
                            input int nh);
        next_seg[s][h][b] = ns;
        next_head[s][h][b] = nh;
    endtask

    task automatic build_table();
        for (int s = 0; s < 7; s++) begin
            for (int h = 0; h < 4; h++) begin
                for (int b = 0; b < 4; b++) begin
                    next_seg[s][h][b] = s;
                    next_head[s][h][b] = h;
                end
            end
        end
        add_move(S_A, H_RIGHT, BTN_RIGHT, S_B, H_DOWN);
        add_move(S_A, H_LEFT, BTN_LEFT, S_F, H_DOWN);
        add_move(S_B, H_UP, BTN_LEFT, S_A, H_LEFT);
        add_move(S_B, H_DOWN, BTN_RIGHT, S_G, H_LEFT);
        add_move(S_B, H_DOWN, BTN_UP, S_C, H_DOWN);
        add_move(S_C, H_UP, BTN_LEFT, S_G, H_LEFT);
        add_move(S_C, H_UP, BTN_UP, S_B, H_UP);
        add_move(S_C, H_DOWN, BTN_RIGHT, S_D, H_DOWN);
        add_move(S_D, H_RIGHT, BTN_LEFT, S_C, H_UP);
        add_move(S_D, H_LEFT, BTN_RIGHT, S_E, H_UP);
        add_move(S_E, H_UP, BTN_RIGHT, S_G, H_RIGHT);
        add_move(S_E, H_UP, BTN_UP, S_F, H_UP);
        add_move(S_E, H_DOWN, BTN_LEFT, S_D, H_RIGHT);
        add_move(S_F, H_UP, BTN_RIGHT, S_A, H_RIGHT);
        add_move(S_F, H_DOWN, BTN_LEFT, S_G, H_RIGHT);
        add_move(S_G, H_RIGHT, BTN_LEFT, S_B, H_UP);
        add_move(S_G, H_RIGHT, BTN_RIGHT, S_C, H_DOWN);
        add_move(S_G, H_LEFT, BTN_LEFT, S_E, H_DOWN);
        add_move(S_G, H_LEFT, BTN_RIGHT, S_F, H_UP);
    endtask

    task automatic check_true(input bit cond, input string msg);
        check_count++;
        a_check: assert (cond) else begin
            $display("[ERROR] %0t: %s", $time, msg);
            err_count++;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        int errs;
        errs = total_errors() - errs_before;
        test_count++;
        if (errs == 0) begin
            $display("Test %0d %s: ok", test_count, name);
        end else begin
            $display("Test %0d %s: %0d error(s)", test_count, name, errs);
        end
    endtask

    // Hold one button through the debounce window, release, then step the model
    task automatic press(input int b);
        int ns;
        int nh;
        @(posedge clk);
        right <= (b == BTN_RIGHT);
        left  <= (b == BTN_LEFT);
        up    <= (b == BTN_UP);
        down  <= (b == BTN_DOWN);
        repeat (PRESS_CYCLES) @(posedge clk);
        right <= 1'b0;
        left  <= 1'b0;
        up    <= 1'b0;
        down  <= 1'b0;
        repeat (RELEASE_CYCLES) @(posedge clk);
        @(negedge clk);
        ns = next_seg[m_seg][m_head][b];
        nh = next_head[m_seg][m_head][b];
        m_seg = ns;
        m_head = nh;
        if (fall) begin
            m_visited = m_visited | (snake_pkg::seg_mask_t'(1) << m_seg);
        end else begin
            m_visited = '0;
        end
    endtask

    task automatic check_walk();
        snake_pkg::seg_mask_t expected;
        expected = snake_pkg::seg_mask_t'(1) << m_seg;
        check_true(~seg == expected,
                   $sformatf("lit segments %b, expected %b", ~seg, expected));
        check_true(int'(pos) == m_head,
                   $sformatf("pos %0d, expected %0d", int'(pos), m_head));
    endtask

    task automatic check_fall_marks();
        snake_pkg::seg_mask_t lit;
        bit                   ok;
        lit = ~seg;
        ok = 1'b1;
        for (int i = 0; i < snake_pkg::NUM_SEGS; i++) begin
            if (i != m_seg && lit[i] != m_visited[i]) begin
                ok = 1'b0;
            end
        end
        check_true(ok, $sformatf("fall shows %b, visited %b, current %0d",
                                 lit, m_visited, m_seg));
        check_true(int'(pos) == m_head,
                   $sformatf("pos %0d in fall, expected %0d", int'(pos), m_head));
    endtask

    task automatic wait_for_move(output int waited);
        waited = 0;
        while (!move) begin
            @(negedge clk);
            waited++;
        end
    endtask

    initial begin
        int errs_before;
        int waited;
        int r;
        int b;

        rst = 1'b1;
        right = 1'b0;
        left = 1'b0;
        up = 1'b0;
        down = 1'b0;
        err_count = 0;
        check_count = 0;
        test_count = 0;
        cycle_count = 0;
        order_fails = 0;
        phase_fails = 0;
        onehot_fails = 0;
        seed = 90328;
        m_seg = S_G;
        m_head = H_LEFT;
        m_visited = '0;
        build_table();

        repeat (4) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);

        errs_before = total_errors();
        check_true(init && !move && !fall, "phase after reset is not init");
        check_true(seg == 7'b0111111, $sformatf("seg after reset is %b", seg));
        check_true(pos == snake_pkg::LEFT, "pos after reset is not LEFT");
        report_test("reset state", errs_before);

        // No buttons, init must time out on its own
        errs_before = total_errors();
        wait_for_move(waited);
        check_true(move && !init && !fall, "move phase not entered");
        check_true(waited >= (2 * snake_pkg::INIT_SECONDS - 1) * CYCLES_PER_HALF,
                   $sformatf("init lasted only %0d cycles", waited));
        report_test("phase order", errs_before);

        // Four rights loop G, F, A, B and back to G/LEFT
        errs_before = total_errors();
        for (int i = 0; i < 4; i++) begin
            press(BTN_RIGHT);
            check_walk();
        end
        report_test("walk in move", errs_before);

        errs_before = total_errors();
        press(BTN_UP);
        check_walk();
        press(BTN_RIGHT);
        press(BTN_LEFT);
        check_walk();
        press(BTN_RIGHT);
        press(BTN_UP);
        check_walk();
        press(BTN_LEFT);
        check_walk();
        press(BTN_RIGHT);
        check_walk();
        // Back to G/LEFT where the fall route starts
        press(BTN_RIGHT);
        check_walk();
        report_test("ignored buttons", errs_before);

        errs_before = total_errors();
        press(BTN_DOWN);
        check_true(fall, "fall not entered after down");
        check_fall_marks();
        foreach (r_seq[i]) begin
            press(r_seq[i]);
            if (fall) begin
                check_fall_marks();
            end
        end
        report_test("fall marking", errs_before);

        errs_before = total_errors();
        check_true(m_visited == 7'h7f || !fall,
                   $sformatf("model visited only %b", m_visited));
        while (!init) begin
            @(negedge clk);
        end
        @(negedge clk);
        @(negedge clk);
        m_seg = S_G;
        m_head = H_LEFT;
        check_true(init && !fall, "init not entered after full mask");
        check_true(seg == 7'b0111111, $sformatf("seg after fall is %b", seg));
        check_true(pos == snake_pkg::LEFT, "pos after fall is not LEFT");
        report_test("end of fall", errs_before);

        errs_before = total_errors();
        wait_for_move(waited);
        for (int i = 0; i < NUM_RANDOM; i++) begin
            r = $random(seed);
            repeat (r & 3) @(posedge clk);
            r = $random(seed);
            b = (r & 32'h7fff_ffff) % 3;
            press(b);
            check_walk();
        end
        report_test("random walk", errs_before);

        $display("Tests: %0d, checks: %0d, errors: %0d",
                 test_count, check_count, total_errors());
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== verif/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock #(
    parameter int HALF_PERIOD_NS = 2
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    // 4 ns period
    always begin
        #(HALF_PERIOD_NS) clk = ~clk;
    end

endmodule
